//--- cache_defines.svh
/*
 * Cache geometry constants for the two-way set-associative cache.
 * Address split, data widths, way and set counts and the bit
 * positions inside a way's tag entry.
 */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// A 16-bit address is tag, set index and byte offset from the top
`define ADDR_WIDTH    16
`define TAG_WIDTH     11
`define INDEX_WIDTH   3
`define OFFSET_WIDTH  2

// Byte-wide ports and four-byte lines
`define BYTE_WIDTH    8
`define LINE_BYTES    4

`define NUM_WAYS      2
`define NUM_SETS      8

// Tag entry layout: valid, used, dirty, then the tag in the low bits
`define ENTRY_VALID_BIT  (`TAG_WIDTH + 2)
`define ENTRY_USED_BIT   (`TAG_WIDTH + 1)
`define ENTRY_DIRTY_BIT  (`TAG_WIDTH)

`endif

//--- cache_geometry_pkg.sv
/*
 * Cache geometry types.
 * Vector types for the address fields, data bytes, cache lines,
 * tag entries and way numbers, sized from the shared constants.
 */
`include "cache_defines.svh"

package cache_geometry_pkg;

	// Full CPU or memory address
	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	// Address fields
	typedef logic [`TAG_WIDTH-1:0] tag_t;
	typedef logic [`INDEX_WIDTH-1:0] index_t;
	typedef logic [`OFFSET_WIDTH-1:0] offset_t;

	// One data byte on either port
	typedef logic [`BYTE_WIDTH-1:0] byte_t;

	// A whole line with byte 0 in the low bits
	typedef logic [`LINE_BYTES*`BYTE_WIDTH-1:0] line_t;

	// Valid, used and dirty bits above the stored tag
	typedef logic [`TAG_WIDTH+2:0] entry_t;

	// Number of a way
	typedef logic [$clog2(`NUM_WAYS)-1:0] way_sel_t;

endpackage

//--- cache_control_pkg.sv
/*
 * Cache controller types.
 * State encoding of the miss/hit FSM and the memory beat counter.
 */
`include "cache_defines.svh"

package cache_control_pkg;

	// LOOKUP decides hit or miss, the others move a line to or from memory
	typedef enum logic [2:0]
	{
		IDLE,
		LOOKUP,
		WRITE_BACK,
		FETCH,
		MEM_WAIT,
		MEM_BEATS,
		FILL
	} ctrl_state_t;

	// Counts the byte beats of one line transfer
	typedef logic [$clog2(`LINE_BYTES)-1:0] beat_t;

endpackage

//--- cpu_request_latch.sv
/*
 * CPU request latch.
 * Registers an accepted read or write with its address fields and
 * write byte, and gives the ways the set index to read each cycle.
 */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cpu_request_latch import cache_geometry_pkg::*;
(
	input  logic    clock,
	input  logic    reset_n,
	input  logic    rd_cpu,
	input  logic    wr_cpu,
	input  logic    accept,
	input  addr_t   addr_cpu,
	input  byte_t   data_in,
	output logic    req_read,
	output logic    req_write,
	output tag_t    req_tag,
	output index_t  req_index,
	output offset_t req_offset,
	output index_t  lookup_index,
	output byte_t   write_byte
);

	// One-cycle request pulses, a read wins if both strobes are high
	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			req_read <= 1'b0;
			req_write <= 1'b0;
		end
		else
		begin
			req_read <= accept && rd_cpu;
			req_write <= accept && wr_cpu && !rd_cpu;
		end
	end

	// Address fields and the write byte stay put until the next accepted request
	always_ff @(posedge clock)
	begin
		if (accept && (rd_cpu || wr_cpu))
		begin
			req_tag <= addr_cpu[`ADDR_WIDTH-1 -: `TAG_WIDTH];
			req_index <= addr_cpu[`OFFSET_WIDTH +: `INDEX_WIDTH];
			req_offset <= addr_cpu[`OFFSET_WIDTH-1:0];
			write_byte <= data_in;
		end
	end

	// The ways read the incoming set at the request edge itself
	// While a request is in flight they keep reading the latched set
	assign lookup_index = accept ? addr_cpu[`OFFSET_WIDTH +: `INDEX_WIDTH] : req_index;

endmodule

//--- cache_way.sv
/*
 * One cache way.
 * Holds a tag entry and a line for every set, both read through an
 * output register, and compares the stored tag with the request tag.
 * Reset leaves every entry invalid.
 */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_way import cache_geometry_pkg::*;
(
	input  logic   clock,
	input  logic   reset_n,
	input  index_t index,
	input  tag_t   tag,
	input  logic   tag_we,
	input  logic   line_we,
	input  entry_t entry_wdata,
	input  line_t  line_wdata,
	output entry_t entry_out,
	output line_t  line_out,
	output logic   hit
);

	// Tag entries per set
	entry_t entries [`NUM_SETS];

	// Line data per set
	line_t lines [`NUM_SETS];

	// Entry storage and its read register
	// Clearing the entries on reset invalidates the whole way
	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			for (int s = 0; s < `NUM_SETS; s++)
			begin
				entries[s] <= '0;
			end
			entry_out <= '0;
		end
		else
		begin
			if (tag_we)
			begin
				entries[index] <= entry_wdata;
			end
			// Read before write, so an update shows up one edge later
			entry_out <= entries[index];
		end
	end

	// Line storage, same read-before-write behaviour as the entries
	always_ff @(posedge clock)
	begin
		if (line_we)
		begin
			lines[index] <= line_wdata;
		end
		line_out <= lines[index];
	end

	// Only a valid entry can match
	assign hit = entry_out[`ENTRY_VALID_BIT] && (entry_out[`TAG_WIDTH-1:0] == tag);

endmodule

//--- way_resolver.sv
/*
 * Way resolver.
 * Merges the per-way hits into one hit, picks the addressed byte of
 * the hitting line, and chooses the replacement victim by LRU with
 * a flag telling whether the victim must be written back first.
 */
`timescale 1ns/10ps
`include "cache_defines.svh"

module way_resolver import cache_geometry_pkg::*;
(
	input  entry_t               way_entries [`NUM_WAYS],
	input  line_t                way_lines [`NUM_WAYS],
	input  logic [`NUM_WAYS-1:0] way_hits,
	input  offset_t              offset,
	output logic                 hit,
	output way_sel_t             hit_way,
	output byte_t                hit_byte,
	output way_sel_t             victim_way,
	output entry_t               victim_entry,
	output line_t                victim_line,
	output logic                 victim_dirty_valid
);

	assign hit = |way_hits;

	// At most one way matches a tag, so the scan order does not matter here
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < `NUM_WAYS; w++)
		begin
			if (way_hits[w])
			begin
				hit_way = way_sel_t'(w);
			end
		end
	end

	// Byte at the request offset within the hitting line
	assign hit_byte = way_lines[hit_way][offset*`BYTE_WIDTH +: `BYTE_WIDTH];

	// Victim choice
	// An empty way is taken first, lowest number first
	// Otherwise the way not marked as used, and way 0 as a last resort
	always_comb
	begin : pick_victim
		logic found;

		found = 1'b0;
		victim_way = '0;
		for (int w = 0; w < `NUM_WAYS; w++)
		begin
			if (!found && !way_entries[w][`ENTRY_VALID_BIT])
			begin
				victim_way = way_sel_t'(w);
				found = 1'b1;
			end
		end
		for (int w = 0; w < `NUM_WAYS; w++)
		begin
			if (!found && !way_entries[w][`ENTRY_USED_BIT])
			begin
				victim_way = way_sel_t'(w);
				found = 1'b1;
			end
		end
	end

	assign victim_entry = way_entries[victim_way];
	assign victim_line = way_lines[victim_way];

	// Only modified data of a live line has to go back to memory
	assign victim_dirty_valid = victim_entry[`ENTRY_VALID_BIT] && victim_entry[`ENTRY_DIRTY_BIT];

endmodule

//--- cache_controller.sv
/*
 * Cache controller.
 * Runs the hit/miss FSM. A hit updates the LRU bits, and a write hit
 * also merges the byte and marks the line dirty. A miss stalls the
 * CPU, writes a dirty victim back, fetches the new line in four
 * memory beats and installs it in the victim way.
 */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_controller import cache_geometry_pkg::*; import cache_control_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset_n,
	input  logic                 req_read,
	input  logic                 req_write,
	input  tag_t                 req_tag,
	input  index_t               req_index,
	input  offset_t              req_offset,
	input  byte_t                write_byte,
	input  logic                 hit,
	input  logic                 victim_dirty_valid,
	input  way_sel_t             hit_way,
	input  way_sel_t             victim_way,
	input  byte_t                hit_byte,
	input  entry_t               victim_entry,
	input  line_t                victim_line,
	input  entry_t               way_entries [`NUM_WAYS],
	input  line_t                way_lines [`NUM_WAYS],
	input  logic                 ready_mem,
	input  byte_t                mem_rdata,
	output logic                 accept,
	output logic                 stall_cpu,
	output logic                 rd_mem,
	output logic                 wr_mem,
	output addr_t                addr_mem,
	output byte_t                mem_wdata,
	output byte_t                data_out,
	output logic [`NUM_WAYS-1:0] tag_we,
	output logic [`NUM_WAYS-1:0] line_we,
	output entry_t               entry_wdata [`NUM_WAYS],
	output line_t                line_wdata
);

	ctrl_state_t state;

	// Set when the request being served is a write
	logic op_write;

	// Victim way and tag, captured when the miss is seen
	way_sel_t victim_way_q;
	tag_t victim_tag_q;

	// Shift registers for the outgoing and incoming line bytes
	line_t wb_line;
	line_t fill_line;

	beat_t beat;

	// Memory has dropped ready since the transfer strobe went up
	logic seen_low;

	// Hitting line with the write byte merged in
	line_t merged_line;

	// New requests are taken only in IDLE with nothing pending
	assign accept = (state == IDLE) && !req_read && !req_write;

	// Byte 0 of the victim goes out first
	assign mem_wdata = wb_line[`BYTE_WIDTH-1:0];

	always_comb
	begin
		merged_line = way_lines[hit_way];
		merged_line[req_offset*`BYTE_WIDTH +: `BYTE_WIDTH] = write_byte;
	end

	// One data bus to the ways, the strobes pick who takes it
	assign line_wdata = (state == FILL) ? fill_line : merged_line;

	// Way updates happen in LOOKUP on a hit and in FILL
	// Every way not being touched gets its used bit cleared, so the
	// touched way becomes the only most recently used one
	always_comb
	begin
		for (int w = 0; w < `NUM_WAYS; w++)
		begin
			entry_wdata[w] = way_entries[w];
			entry_wdata[w][`ENTRY_USED_BIT] = 1'b0;
			tag_we[w] = 1'b0;
			line_we[w] = 1'b0;
			if (state == LOOKUP && hit)
			begin
				tag_we[w] = 1'b1;
				if (way_sel_t'(w) == hit_way)
				begin
					entry_wdata[w][`ENTRY_USED_BIT] = 1'b1;
					if (op_write)
					begin
						entry_wdata[w][`ENTRY_DIRTY_BIT] = 1'b1;
						line_we[w] = 1'b1;
					end
				end
			end
			else if (state == FILL)
			begin
				tag_we[w] = 1'b1;
				if (way_sel_t'(w) == victim_way_q)
				begin
					// Fresh line: valid, used, clean
					entry_wdata[w] = {1'b1, 1'b1, 1'b0, req_tag};
					line_we[w] = 1'b1;
				end
			end
		end
	end

	// FSM and the memory port strobes
	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= IDLE;
			op_write <= 1'b0;
			stall_cpu <= 1'b0;
			rd_mem <= 1'b0;
			wr_mem <= 1'b0;
			addr_mem <= '0;
			data_out <= '0;
			seen_low <= 1'b0;
			beat <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (req_read || req_write)
					begin
						op_write <= req_write;
						state <= LOOKUP;
					end
				end
				LOOKUP:
				begin
					if (hit)
					begin
						if (!op_write)
						begin
							data_out <= hit_byte;
						end
						state <= IDLE;
					end
					else
					begin
						// Miss: stall now, move on once memory is ready
						stall_cpu <= 1'b1;
						if (ready_mem)
						begin
							state <= victim_dirty_valid ? WRITE_BACK : FETCH;
						end
					end
				end
				WRITE_BACK:
				begin
					if (ready_mem)
					begin
						addr_mem <= {victim_tag_q, req_index, `OFFSET_WIDTH'(0)};
						wr_mem <= 1'b1;
						seen_low <= 1'b0;
						state <= MEM_WAIT;
					end
				end
				FETCH:
				begin
					if (ready_mem)
					begin
						addr_mem <= {req_tag, req_index, `OFFSET_WIDTH'(0)};
						rd_mem <= 1'b1;
						seen_low <= 1'b0;
						state <= MEM_WAIT;
					end
				end
				MEM_WAIT:
				begin
					// Ready has to fall and rise again before the beats start
					if (!ready_mem)
					begin
						seen_low <= 1'b1;
					end
					else if (seen_low)
					begin
						beat <= '0;
						state <= MEM_BEATS;
					end
				end
				MEM_BEATS:
				begin
					beat <= beat + 1'b1;
					if (beat == beat_t'(`LINE_BYTES - 1))
					begin
						rd_mem <= 1'b0;
						wr_mem <= 1'b0;
						// A finished write-back is followed by the fetch
						state <= wr_mem ? FETCH : FILL;
					end
				end
				FILL:
				begin
					stall_cpu <= 1'b0;
					state <= IDLE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Victim capture and the byte shift registers
	always_ff @(posedge clock)
	begin
		case (state)
			LOOKUP:
			begin
				if (!hit)
				begin
					victim_way_q <= victim_way;
					victim_tag_q <= victim_entry[`TAG_WIDTH-1:0];
					wb_line <= victim_line;
				end
			end
			MEM_BEATS:
			begin
				if (wr_mem)
				begin
					wb_line <= wb_line >> `BYTE_WIDTH;
				end
				else
				begin
					// Bytes arrive lowest offset first and end up at the bottom
					fill_line <= {mem_rdata, fill_line[`LINE_BYTES*`BYTE_WIDTH-1:`BYTE_WIDTH]};
				end
			end
			default:
			begin
			end
		endcase
	end

endmodule

//--- cache_2way_top.sv
/*
 * Two-way set-associative cache, top level.
 * Connects the request latch, the generated ways, the way resolver
 * and the controller between the CPU port and the memory port.
 */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_2way_top import cache_geometry_pkg::*;
(
	input  logic  clock,
	input  logic  reset_n,
	input  logic  rd_cpu,
	input  logic  wr_cpu,
	input  addr_t addr_cpu,
	input  byte_t data_in,
	input  logic  ready_mem,
	input  byte_t mem_rdata,
	output byte_t data_out,
	output logic  stall_cpu,
	output logic  rd_mem,
	output logic  wr_mem,
	output addr_t addr_mem,
	output byte_t mem_wdata
);

	// Latched request
	logic accept;
	logic req_read;
	logic req_write;
	tag_t req_tag;
	index_t req_index;
	index_t lookup_index;
	offset_t req_offset;
	byte_t write_byte;

	// Way read side
	entry_t way_entries [`NUM_WAYS];
	line_t way_lines [`NUM_WAYS];
	logic [`NUM_WAYS-1:0] way_hits;

	// Way write side
	logic [`NUM_WAYS-1:0] tag_we;
	logic [`NUM_WAYS-1:0] line_we;
	entry_t entry_wdata [`NUM_WAYS];
	line_t line_wdata;

	// Resolved hit and victim
	logic hit;
	way_sel_t hit_way;
	byte_t hit_byte;
	way_sel_t victim_way;
	entry_t victim_entry;
	line_t victim_line;
	logic victim_dirty_valid;

	cpu_request_latch request_latch_i
	(
		.clock        (clock),
		.reset_n      (reset_n),
		.rd_cpu       (rd_cpu),
		.wr_cpu       (wr_cpu),
		.accept       (accept),
		.addr_cpu     (addr_cpu),
		.data_in      (data_in),
		.req_read     (req_read),
		.req_write    (req_write),
		.req_tag      (req_tag),
		.req_index    (req_index),
		.req_offset   (req_offset),
		.lookup_index (lookup_index),
		.write_byte   (write_byte)
	);

	// All ways see the same set index, tag and line data
	for (genvar w = 0; w < `NUM_WAYS; w++)
	begin : g_way
		cache_way way_i
		(
			.clock       (clock),
			.reset_n     (reset_n),
			.index       (lookup_index),
			.tag         (req_tag),
			.tag_we      (tag_we[w]),
			.line_we     (line_we[w]),
			.entry_wdata (entry_wdata[w]),
			.line_wdata  (line_wdata),
			.entry_out   (way_entries[w]),
			.line_out    (way_lines[w]),
			.hit         (way_hits[w])
		);
	end

	way_resolver way_resolver_i
	(
		.way_entries        (way_entries),
		.way_lines          (way_lines),
		.way_hits           (way_hits),
		.offset             (req_offset),
		.hit                (hit),
		.hit_way            (hit_way),
		.hit_byte           (hit_byte),
		.victim_way         (victim_way),
		.victim_entry       (victim_entry),
		.victim_line        (victim_line),
		.victim_dirty_valid (victim_dirty_valid)
	);

	cache_controller cache_controller_i
	(
		.clock              (clock),
		.reset_n            (reset_n),
		.req_read           (req_read),
		.req_write          (req_write),
		.req_tag            (req_tag),
		.req_index          (req_index),
		.req_offset         (req_offset),
		.write_byte         (write_byte),
		.hit                (hit),
		.victim_dirty_valid (victim_dirty_valid),
		.hit_way            (hit_way),
		.victim_way         (victim_way),
		.hit_byte           (hit_byte),
		.victim_entry       (victim_entry),
		.victim_line        (victim_line),
		.way_entries        (way_entries),
		.way_lines          (way_lines),
		.ready_mem          (ready_mem),
		.mem_rdata          (mem_rdata),
		.accept             (accept),
		.stall_cpu          (stall_cpu),
		.rd_mem             (rd_mem),
		.wr_mem             (wr_mem),
		.addr_mem           (addr_mem),
		.mem_wdata          (mem_wdata),
		.data_out           (data_out),
		.tag_we             (tag_we),
		.line_we            (line_we),
		.entry_wdata        (entry_wdata),
		.line_wdata         (line_wdata)
	);

endmodule

//--- cache_clock_gen.sv
/*
 * Testbench clock and reset.
 * Free-running 40 ns clock, reset held low for the first eight
 * rising edges and released on the eighth.
 */
`timescale 1ns/10ps

module cache_clock_gen
(
	output logic clock,
	output logic reset_n
);

	// Half of the 40 ns period
	initial
	begin
		clock = 1'b0;
		forever
		begin
			#20 clock = ~clock;
		end
	end

	initial
	begin
		reset_n = 1'b0;
		repeat (8) @(posedge clock);
		reset_n <= 1'b1;
	end

endmodule

//--- cache_assertions.sv
/*
 * Protocol checks on the cache top level.
 * Memory strobes never overlap, the CPU is stalled while memory is
 * busy, and a read that hits in LOOKUP never stalls the CPU.
 */
`timescale 1ns/10ps

module cache_assertions
(
	input logic clock,
	input logic reset_n,
	input logic rd_mem,
	input logic wr_mem,
	input logic stall_cpu,
	input logic req_read,
	input logic hit
);

	// Read by the testbench at the end of the run
	int failures = 0;

	// A line moves in one direction at a time
	property strobes_exclusive;
		@(posedge clock) disable iff (!reset_n)
		!(rd_mem && wr_mem);
	endproperty

	// Any memory transfer belongs to a miss, so the CPU waits
	property stall_during_transfer;
		@(posedge clock) disable iff (!reset_n)
		(rd_mem || wr_mem) |-> stall_cpu;
	endproperty

	// The cycle after a read request is LOOKUP, a hit there must not stall
	property read_hit_no_stall;
		@(posedge clock) disable iff (!reset_n)
		req_read ##1 hit |=> !stall_cpu;
	endproperty

	assert property (strobes_exclusive)
	else
	begin
		failures++;
		$error("rd_mem and wr_mem are high together");
	end

	assert property (stall_during_transfer)
	else
	begin
		failures++;
		$error("memory strobe is high while stall_cpu is low");
	end

	assert property (read_hit_no_stall)
	else
	begin
		failures++;
		$error("stall_cpu rose after a read hit");
	end

endmodule

bind cache_2way_top cache_assertions assertions_i
(
	.clock     (clock),
	.reset_n   (reset_n),
	.rd_mem    (rd_mem),
	.wr_mem    (wr_mem),
	.stall_cpu (stall_cpu),
	.req_read  (req_read),
	.hit       (hit)
);

//--- cache_tb.sv
/*
 * Testbench for the two-way set-associative cache.
 * Replays CPU operations from the stimulus file, reissues every
 * request that stalled, models main memory with a varying ready
 * delay and checks the read bytes and the write-backs of each test.
 */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_tb import cache_geometry_pkg::*;
();

	localparam int CYCLES_PER_TEST = 60;
	localparam int RESET_CYCLES = 8;
	localparam int MEM_BYTES = 1 << `ADDR_WIDTH;
	localparam logic [31:0] RANDOM_SEED = 32'h7dfd_04b9;

	logic clock;
	logic reset_n;

	// CPU port
	logic rd_cpu;
	logic wr_cpu;
	addr_t addr_cpu;
	byte_t data_in;
	byte_t data_out;
	logic stall_cpu;

	// Memory port
	logic ready_mem;
	byte_t mem_rdata;
	logic rd_mem;
	logic wr_mem;
	addr_t addr_mem;
	byte_t mem_wdata;

	// Main memory contents
	byte_t mem_bytes [MEM_BYTES];

	// Memory activity seen during the current test
	logic wb_seen;
	int wb_beats;
	int mem_transfers;

	int error_count = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	// One entry per stimulus line
	logic op_list [$];
	addr_t addr_list [$];
	byte_t wdata_list [$];
	byte_t rdata_list [$];
	logic wb_list [$];

	// Expected contents of every set, kept by the replacement rules
	bit ref_valid [`NUM_SETS][`NUM_WAYS];
	bit ref_used [`NUM_SETS][`NUM_WAYS];
	tag_t ref_tag [`NUM_SETS][`NUM_WAYS];

	cache_clock_gen clock_gen_i
	(
		.clock   (clock),
		.reset_n (reset_n)
	);

	cache_2way_top cache_2way_top_i
	(
		.clock     (clock),
		.reset_n   (reset_n),
		.rd_cpu    (rd_cpu),
		.wr_cpu    (wr_cpu),
		.addr_cpu  (addr_cpu),
		.data_in   (data_in),
		.ready_mem (ready_mem),
		.mem_rdata (mem_rdata),
		.data_out  (data_out),
		.stall_cpu (stall_cpu),
		.rd_mem    (rd_mem),
		.wr_mem    (wr_mem),
		.addr_mem  (addr_mem),
		.mem_wdata (mem_wdata)
	);

	// Ends a hung run, the limit is set once the stimulus is known
	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// Main memory model
	// Each byte holds its low address byte XOR its high address byte XOR 5A
	// A transfer drops ready, raises it after a random delay, and the
	// line then moves in four beats on the following edges
	initial
	begin : memory_model
		addr_t base;
		logic is_write;
		int delay;

		void'($urandom(RANDOM_SEED));
		for (int a = 0; a < MEM_BYTES; a++)
		begin
			mem_bytes[a] = byte_t'(a) ^ byte_t'(a >> 8) ^ 8'h5A;
		end
		ready_mem = 1'b1;
		mem_rdata = '0;
		forever
		begin
			@(posedge clock);
			if (rd_mem || wr_mem)
			begin
				is_write = wr_mem;
				base = addr_mem;
				mem_transfers++;
				ready_mem <= 1'b0;
				delay = 1 + ($urandom % 4);
				repeat (delay) @(posedge clock);
				ready_mem <= 1'b1;
				// The controller sees ready on the next edge and starts the beats
				@(posedge clock);
				if (!is_write)
				begin
					mem_rdata <= mem_bytes[base];
				end
				for (int k = 0; k < `LINE_BYTES; k++)
				begin
					@(posedge clock);
					if (is_write)
					begin
						mem_bytes[base + k] = mem_wdata;
						// A beat counts only while the controller still holds wr_mem
						if (wr_mem)
						begin
							wb_beats++;
						end
					end
					else if (k < `LINE_BYTES - 1)
					begin
						mem_rdata <= mem_bytes[base + k + 1];
					end
				end
				if (is_write)
				begin
					wb_seen = 1'b1;
				end
			end
		end
	end

	// Columns are opcode, address, write byte, expected read byte and
	// expected write-back flag, lines that do not parse are skipped
	task automatic load_stimulus();
		int fd;
		int n;
		logic [31:0] f_op;
		logic [31:0] f_addr;
		logic [31:0] f_wdata;
		logic [31:0] f_rdata;
		logic [31:0] f_wb;
		logic [8*160-1:0] skipped;

		fd = $fopen("cache_stim.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the stimulus file cache_stim.txt");
			error_count++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				n = $fscanf(fd, "%h %h %h %h %h", f_op, f_addr, f_wdata, f_rdata, f_wb);
				if (n == 5)
				begin
					op_list.push_back(f_op[0]);
					addr_list.push_back(addr_t'(f_addr));
					wdata_list.push_back(byte_t'(f_wdata));
					rdata_list.push_back(byte_t'(f_rdata));
					wb_list.push_back(f_wb[0]);
				end
				else
				begin
					void'($fgets(skipped, fd));
				end
			end
			$fclose(fd);
		end
	endtask

	// Looks an access up in the expected contents and applies its effect
	// A miss takes an empty way, lowest number first, else the way not
	// used last, else way 0
	task automatic predict_access(input addr_t addr, output logic miss);
		int set_idx;
		int way;
		tag_t tag;

		set_idx = int'(addr[`OFFSET_WIDTH +: `INDEX_WIDTH]);
		tag = addr[`ADDR_WIDTH-1 -: `TAG_WIDTH];
		way = -1;
		for (int w = 0; w < `NUM_WAYS; w++)
		begin
			if (ref_valid[set_idx][w] && ref_tag[set_idx][w] == tag)
			begin
				way = w;
			end
		end
		miss = (way < 0);
		if (miss)
		begin
			way = 0;
			for (int w = `NUM_WAYS - 1; w >= 0; w--)
			begin
				if (!ref_used[set_idx][w])
				begin
					way = w;
				end
			end
			for (int w = `NUM_WAYS - 1; w >= 0; w--)
			begin
				if (!ref_valid[set_idx][w])
				begin
					way = w;
				end
			end
			ref_valid[set_idx][way] = 1'b1;
			ref_tag[set_idx][way] = tag;
		end
		// The accessed way becomes the only recently used one in its set
		for (int w = 0; w < `NUM_WAYS; w++)
		begin
			ref_used[set_idx][w] = (w == way);
		end
	endtask

	// One-cycle strobe, then wait until the lookup result is out
	// The request is latched on the second edge and answered two edges later
	task automatic issue_request(input logic is_write, input addr_t addr, input byte_t wbyte);
		@(posedge clock);
		rd_cpu <= !is_write;
		wr_cpu <= is_write;
		addr_cpu <= addr;
		data_in <= wbyte;
		@(posedge clock);
		rd_cpu <= 1'b0;
		wr_cpu <= 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
	endtask

	task automatic run_test(input int t);
		logic is_write;
		addr_t addr;
		byte_t exp_rdata;
		logic exp_wb;
		logic exp_miss;
		logic missed;
		int errors_before;

		is_write = op_list[t];
		addr = addr_list[t];
		exp_rdata = rdata_list[t];
		exp_wb = wb_list[t];
		errors_before = error_count;
		wb_seen = 1'b0;
		wb_beats = 0;
		mem_transfers = 0;
		predict_access(addr, exp_miss);

		issue_request(is_write, addr, wdata_list[t]);
		missed = stall_cpu;

		// A hit leaves the CPU running, a miss stalls it
		assert (missed == exp_miss)
		else
		begin
			$display("[FAIL] %0t ns: stall_cpu = %b, expected %b", $time, missed, exp_miss);
			error_count++;
		end

		if (missed)
		begin
			// Stall falls when the new line is installed
			while (stall_cpu)
			begin
				@(negedge clock);
			end
			issue_request(is_write, addr, wdata_list[t]);
			assert (!stall_cpu)
			else
			begin
				$display("Test %0d: the request to %h missed again after its line fill",
					t + 1, addr);
				error_count++;
			end
		end

		if (!is_write)
		begin
			assert (data_out == exp_rdata)
			else
			begin
				$display("[FAIL] %0t ns: data_out = %h, expected %h", $time, data_out, exp_rdata);
				error_count++;
			end
		end

		assert (wb_seen == exp_wb)
		else
		begin
			$display("[FAIL] %0t ns: wr_mem write-back = %0d, expected %0d",
				$time, wb_seen, exp_wb);
			error_count++;
		end

		assert (!exp_wb || wb_beats == `LINE_BYTES)
		else
		begin
			$display("Test %0d: the write-back moved %0d bytes instead of a whole line",
				t + 1, wb_beats);
			error_count++;
		end

		if (error_count != errors_before)
		begin
			tests_failed++;
		end
		$display("test %2d: %s %h %s, %0d memory transfers, %s", t + 1,
			is_write ? "write" : "read ", addr, missed ? "miss" : "hit ",
			mem_transfers, (error_count == errors_before) ? "ok" : "mismatch");
	endtask

	initial
	begin : main_sequence
		int assertion_failures;

		rd_cpu = 1'b0;
		wr_cpu = 1'b0;
		addr_cpu = '0;
		data_in = '0;

		load_stimulus();
		cycle_limit = CYCLES_PER_TEST * addr_list.size() + 2 * RESET_CYCLES;
		if (addr_list.size() == 0)
		begin
			$display("The stimulus file holds no operations");
			error_count++;
		end

		@(posedge reset_n);
		@(negedge clock);

		// Outputs come out of reset idle and cleared
		assert (data_out == '0)
		else
		begin
			$display("[FAIL] %0t ns: data_out = %h, expected %h", $time, data_out, 8'h00);
			error_count++;
		end
		assert (!stall_cpu)
		else
		begin
			$display("[FAIL] %0t ns: stall_cpu = %b, expected %b", $time, stall_cpu, 1'b0);
			error_count++;
		end

		for (int t = 0; t < addr_list.size(); t++)
		begin
			run_test(t);
		end

		assertion_failures = cache_2way_top_i.assertions_i.failures;
		$display("%0d tests run, %0d with errors, %0d check errors, %0d assertion failures",
			addr_list.size(), tests_failed, error_count, assertion_failures);
		if (error_count == 0 && assertion_failures == 0)
		begin
			$display("Simulation PASSED");
		end
		else
		begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- cache_stim.txt
# op (0 read, 1 write)  address  write byte  expected read byte  expected write-back
# all hex, memory byte = low address byte ^ high address byte ^ 5a
0 0004 00 5e 0
0 0005 00 5f 0
0 0006 00 5c 0
0 0007 00 5d 0
1 0006 a5 00 0
0 0006 00 a5 0
0 0024 00 7e 0
0 0044 00 1e 1
0 0006 00 a5 0
0 0005 00 5f 0
1 0109 3c 00 0
0 0109 00 3c 0
0 0108 00 53 0
0 010a 00 51 0
0 010b 00 50 0
0 0129 00 72 0
1 012a c3 00 0
0 0148 00 13 1
0 016a 00 31 1
0 012a 00 c3 0
0 0109 00 3c 0
1 020e 77 00 0
0 022d 00 75 0
0 024c 00 14 1
0 020e 00 77 0
0 020c 00 54 0
0 020f 00 57 0
0 024d 00 15 0
0 022c 00 74 0
0 024f 00 17 0

//--- list.f
+incdir+.
cache_geometry_pkg.sv
cache_control_pkg.sv
cpu_request_latch.sv
cache_way.sv
way_resolver.sv
cache_controller.sv
cache_2way_top.sv
cache_clock_gen.sv
cache_assertions.sv
cache_tb.sv
